/* Bender.yml */
package:
  name: itrace

sources:
  - include_dirs:
      - include
    files:
      - src/itrace_pkg.sv
      - src/itrace_capture.sv
      - src/itrace_buffer.sv
      - src/inst_ascii_decoder.sv
      - src/itrace_emitter.sv
      - src/itrace_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/itrace_tb.sv

/* dv/itrace_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itrace_defines.svh"

module itrace_tb;

    localparam int TABLE_SIZE = 16;
    localparam int DRAIN_LIMIT = 100;

    logic                    clk;
    logic                    reset;
    logic                    retire_valid;
    itrace_pkg::pc_t         retire_pc;
    itrace_pkg::instr_t      retire_instr;
    logic                    out_ready;
    logic                    out_valid;
    itrace_pkg::pc_t         out_pc;
    itrace_pkg::instr_t      out_instr;
    itrace_pkg::mnemonic_t   out_mnemonic;
    itrace_pkg::drop_count_t drop_count;

    // Expected text that travels with the beat on the retire side
    itrace_pkg::mnemonic_t   cur_mnem;

    itrace_pkg::instr_t      tbl_instr [TABLE_SIZE];
    itrace_pkg::mnemonic_t   tbl_mnem  [TABLE_SIZE];

    // Accepted beats, oldest first
    itrace_pkg::pc_t         pc_q    [$];
    itrace_pkg::instr_t      instr_q [$];
    itrace_pkg::mnemonic_t   mnem_q  [$];

    // Reference model state
    itrace_pkg::credit_t     m_credits;
    itrace_pkg::credit_t     m_buf_cnt;
    logic                    m_push_d;
    logic                    m_credit_ret;
    logic                    exp_valid;
    logic                    exp_any;
    itrace_pkg::pc_t         exp_pc;
    itrace_pkg::instr_t      exp_instr;
    itrace_pkg::mnemonic_t   exp_mnem;
    itrace_pkg::drop_count_t exp_drops;
    int                      accepted_total;
    int                      records_seen;

    int                      retire_total;
    int                      mismatch_count;
    int                      other_count;
    int                      seed;

    itrace_top i_itrace_top (
        .clk          (clk),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_instr    (out_instr),
        .out_mnemonic (out_mnemonic),
        .drop_count   (drop_count)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Credit and occupancy model, from the port timing rules
    always @(posedge clk) begin : ref_model
        logic pop_now;
        logic take_now;
        logic hs_now;
        if (reset) begin
            m_credits      <= itrace_pkg::credit_t'(`ITRACE_BUF_DEPTH);
            m_buf_cnt      <= '0;
            m_push_d       <= 1'b0;
            m_credit_ret   <= 1'b0;
            exp_valid      <= 1'b0;
            exp_any        <= 1'b0;
            exp_drops      <= '0;
            accepted_total <= 0;
            records_seen   <= 0;
            pc_q.delete();
            instr_q.delete();
            mnem_q.delete();
        end else begin
            pop_now  = (m_buf_cnt != '0) && (!exp_valid || out_ready);
            hs_now   = exp_valid && out_ready;
            take_now = retire_valid && ((m_credits != '0) || m_credit_ret);

            m_credits    <= m_credits + m_credit_ret - take_now;
            m_buf_cnt    <= m_buf_cnt + m_push_d - pop_now;
            m_push_d     <= take_now;
            m_credit_ret <= pop_now;
            if (pop_now) begin
                exp_valid <= 1'b1;
            end else if (out_ready) begin
                exp_valid <= 1'b0;
            end

            // Records actually taken by the sink
            if (out_valid && out_ready) begin
                records_seen <= records_seen + 1;
            end

            if (hs_now) begin
                void'(pc_q.pop_front());
                void'(instr_q.pop_front());
                void'(mnem_q.pop_front());
            end
            if (take_now) begin
                pc_q.push_back(retire_pc);
                instr_q.push_back(retire_instr);
                mnem_q.push_back(cur_mnem);
                accepted_total <= accepted_total + 1;
            end else if (retire_valid && (exp_drops != '1)) begin
                exp_drops <= exp_drops + 1'b1;
            end

            // Front of the queue is the record the sink sees next
            exp_any <= (pc_q.size() != 0);
            if (pc_q.size() != 0) begin
                exp_pc    <= pc_q[0];
                exp_instr <= instr_q[0];
                exp_mnem  <= mnem_q[0];
            end
        end
    end

    ////////////////////
    // Checks
    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> !out_valid && (drop_count == '0))
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: out_valid or drop_count not cleared by reset", $time);
        end

    a_valid_track: assert property (@(posedge clk) disable iff (reset)
        out_valid == exp_valid)
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: out_valid is %0b, expected %0b",
                     $time, $sampled(out_valid), $sampled(exp_valid));
        end

    a_record_match: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready |-> exp_any && (out_pc == exp_pc) && (out_instr == exp_instr))
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: record pc %h instr %h, expected pc %h instr %h",
                     $time, $sampled(out_pc), $sampled(out_instr),
                     $sampled(exp_pc), $sampled(exp_instr));
        end

    a_mnemonic_match: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready && exp_any |-> out_mnemonic == exp_mnem)
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: mnemonic %s for instr %h, expected %s",
                     $time, $sampled(out_mnemonic), $sampled(out_instr), $sampled(exp_mnem));
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_instr)
            && $stable(out_mnemonic))
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: output record changed while the sink stalled", $time);
        end

    a_drop_track: assert property (@(posedge clk) disable iff (reset)
        drop_count == exp_drops)
        else begin
            mismatch_count++;
            $display("Mismatch at %0t: drop_count %0d, expected %0d",
                     $time, $sampled(drop_count), $sampled(exp_drops));
        end

    ////////////////////
    // Stimulus helpers
    task automatic set_entry(input int idx, input itrace_pkg::instr_t instr,
                             input itrace_pkg::mnemonic_t mnem);
        tbl_instr[idx] = instr;
        tbl_mnem[idx]  = mnem;
    endtask

    task automatic load_table();
        set_entry(0,  {`OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, `FN_ADDU}, "ADDU");
        set_entry(1,  {`OP_ADDIU, 5'd4, 5'd5, 16'h0010}, "ADDIU");
        set_entry(2,  {`OP_J, 26'h0000100}, "J");
        set_entry(3,  {`OP_BEQ, 5'd1, 5'd2, 16'hfffc}, "BEQ");
        set_entry(4,  {`OP_LW, 5'd29, 5'd8, 16'h0004}, "LW");
        set_entry(5,  {`OP_SW, 5'd29, 5'd9, 16'h0008}, "SW");
        set_entry(6,  {`OP_REGIMM, 5'd3, `RT_BGEZAL, 16'h0010}, "BGEZAL");
        set_entry(7,  {`OP_REGIMM, 5'd6, `RT_TGEI, 16'h0001}, "TGEI");
        set_entry(8,  {`OP_REGIMM, 5'd6, `RT_TGEIU, 16'h0002}, "TGEIU");
        set_entry(9,  {`OP_COP0, `RS_MTC0, 5'd8, 5'd12, 5'd0, 6'd0}, "MTC0");
        set_entry(10, {`OP_COP0, 5'b10000, 15'd0, `FN_ERET}, "ERET");
        set_entry(11, {`OP_SPECIAL2, 5'd4, 5'd5, 5'd6, 5'd0, `FN_MUL}, "MUL");
        set_entry(12, {`OP_CACHE, 5'd4, 5'd0, 16'h0020}, "CACHE");
        set_entry(13, {`OP_PREF, 5'd4, 5'd1, 16'h0040}, "PREF");
        set_entry(14, 32'h0000_0000, "NOP");
        // Opcode 6'b111111 is unused
        set_entry(15, {6'b111111, 26'h0}, "N-R");
    endtask

    // One cycle of inputs, applied on the falling edge
    task automatic step(input logic valid, input itrace_pkg::pc_t pc, input int idx,
                        input logic ready);
        @(negedge clk);
        retire_valid = valid;
        retire_pc    = pc;
        retire_instr = tbl_instr[idx];
        cur_mnem     = tbl_mnem[idx];
        out_ready    = ready;
        if (valid) begin
            retire_total++;
        end
    endtask

    task automatic print_counts();
        $display("Error summary: %0d mismatches, %0d other failures",
                 mismatch_count, other_count);
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while ((pc_q.size() != 0) && (waited < limit)) begin
            step(1'b0, '0, 0, 1'b1);
            waited++;
        end
        if (pc_q.size() != 0) begin
            other_count++;
            $display("Timeout: %0d accepted records were not emitted within %0d cycles",
                     pc_q.size(), limit);
            print_counts();
            $display("Test failed");
            $finish;
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        int drops_before;
        int accepted_before;
        int delta_drops;
        clk            = 1'b0;
        reset          = 1'b1;
        retire_valid   = 1'b0;
        retire_pc      = '0;
        retire_instr   = '0;
        out_ready      = 1'b0;
        cur_mnem       = '0;
        retire_total   = 0;
        mismatch_count = 0;
        other_count    = 0;
        seed           = 45719;
        load_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) step(1'b0, '0, 0, 1'b1);

        // Back to back retires, every table entry twice
        for (int i = 0; i < 2 * TABLE_SIZE; i++) begin
            step(1'b1, 32'h0040_0000 + 4 * i, i % TABLE_SIZE, 1'b1);
        end
        wait_drain(DRAIN_LIMIT);

        // Sink stalled, buffer fills and later beats drop
        drops_before    = drop_count;
        accepted_before = accepted_total;
        for (int i = 0; i < 12; i++) begin
            step(1'b1, 32'h0050_0000 + 4 * i, i, 1'b0);
        end
        repeat (6) step(1'b0, '0, 0, 1'b0);
        delta_drops = drop_count - drops_before;
        if (delta_drops != 12 - (accepted_total - accepted_before)) begin
            mismatch_count++;
            $display("Mismatch at %0t: %0d beats dropped during stall, expected %0d",
                     $time, delta_drops, 12 - (accepted_total - accepted_before));
        end
        if (delta_drops == 0) begin
            other_count++;
            $display("Stalling the sink never made the capture stage drop a beat");
        end
        wait_drain(DRAIN_LIMIT);

        // Random retires against a random sink
        for (int i = 0; i < 300; i++) begin
            step(($random(seed) & 3) != 0, 32'h0060_0000 + 4 * i,
                 $random(seed) & (TABLE_SIZE - 1), $random(seed) & 1);
        end
        wait_drain(DRAIN_LIMIT);
        repeat (3) step(1'b0, '0, 0, 1'b1);

        if (records_seen + drop_count != retire_total) begin
            mismatch_count++;
            $display("Mismatch at %0t: %0d records plus %0d drops, expected %0d retires",
                     $time, records_seen, drop_count, retire_total);
        end

        print_counts();
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* include/itrace_defines.svh */
`ifndef ITRACE_DEFINES_SVH
`define ITRACE_DEFINES_SVH

// Trace buffer entries, also the credit pool size
`define ITRACE_BUF_DEPTH 4
`define ITRACE_MNEM_CHARS 6

////////////////////
// Primary opcodes, instr[31:26]
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000
`define OP_SPECIAL2 6'b011100
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LWL      6'b100010
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_LWR      6'b100110
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SWL      6'b101010
`define OP_SW       6'b101011
`define OP_SWR      6'b101110
`define OP_CACHE    6'b101111
`define OP_LL       6'b110000
`define OP_PREF     6'b110011
`define OP_SC       6'b111000

////////////////////
// SPECIAL function field, instr[5:0]
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_SYSCALL  6'b001100
`define FN_BREAK    6'b001101
`define FN_SYNC     6'b001111
`define FN_MFHI     6'b010000
`define FN_MTHI     6'b010001
`define FN_MFLO     6'b010010
`define FN_MTLO     6'b010011
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_DIV      6'b011010
`define FN_DIVU     6'b011011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011
`define FN_TGE      6'b110000
`define FN_TGEU     6'b110001
`define FN_TLT      6'b110010
`define FN_TLTU     6'b110011
`define FN_TEQ      6'b110100
`define FN_TNE      6'b110110

// COP0 function field
`define FN_TLBR     6'b000001
`define FN_TLBWI    6'b000010
`define FN_TLBP     6'b001000
`define FN_ERET     6'b011000
`define FN_WAIT     6'b100000

// SPECIAL2 function field
`define FN_MADD     6'b000000
`define FN_MADDU    6'b000001
`define FN_MUL      6'b000010
`define FN_MSUB     6'b000100
`define FN_MSUBU    6'b000101
`define FN_CLZ      6'b100000
`define FN_CLO      6'b100001

////////////////////
// REGIMM rt field, instr[20:16]
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_TGEI     5'b01000
`define RT_TGEIU    5'b01001
`define RT_TLTI     5'b01010
`define RT_TLTIU    5'b01011
`define RT_TEQI     5'b01100
`define RT_TNEI     5'b01110
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

// COP0 rs field, instr[25:21]
`define RS_MFC0     5'b00000
`define RS_MTC0     5'b00100

`endif

/* itrace.f */
+incdir+include
src/itrace_pkg.sv
src/itrace_capture.sv
src/itrace_buffer.sv
src/inst_ascii_decoder.sv
src/itrace_emitter.sv
src/itrace_top.sv
dv/itrace_tb.sv

/* src/inst_ascii_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itrace_defines.svh"

module inst_ascii_decoder (
    input  wire itrace_pkg::instr_t instr,
    output itrace_pkg::mnemonic_t   mnemonic
);

    // Short names land right-aligned, zero bytes on the left
    always_comb begin
        mnemonic = "N-R";
        case (instr[31:26])
            `OP_SPECIAL: begin
                case (instr[5:0])
                    // Shifts
                    `FN_SLL:     mnemonic = "SLL";
                    `FN_SRL:     mnemonic = "SRL";
                    `FN_SRA:     mnemonic = "SRA";
                    `FN_SLLV:    mnemonic = "SLLV";
                    `FN_SRLV:    mnemonic = "SRLV";
                    `FN_SRAV:    mnemonic = "SRAV";
                    // Jumps and system
                    `FN_JR:      mnemonic = "JR";
                    `FN_JALR:    mnemonic = "JALR";
                    `FN_SYSCALL: mnemonic = "SYSC";
                    `FN_BREAK:   mnemonic = "BREAK";
                    `FN_SYNC:    mnemonic = "SYNC";
                    // HI/LO moves
                    `FN_MFHI:    mnemonic = "MFHI";
                    `FN_MTHI:    mnemonic = "MTHI";
                    `FN_MFLO:    mnemonic = "MFLO";
                    `FN_MTLO:    mnemonic = "MTLO";
                    `FN_MULT:    mnemonic = "MULT";
                    `FN_MULTU:   mnemonic = "MULTU";
                    `FN_DIV:     mnemonic = "DIV";
                    `FN_DIVU:    mnemonic = "DIVU";
                    // ALU
                    `FN_ADD:     mnemonic = "ADD";
                    `FN_ADDU:    mnemonic = "ADDU";
                    `FN_SUB:     mnemonic = "SUB";
                    `FN_SUBU:    mnemonic = "SUBU";
                    `FN_AND:     mnemonic = "AND";
                    `FN_OR:      mnemonic = "OR";
                    `FN_XOR:     mnemonic = "XOR";
                    `FN_NOR:     mnemonic = "NOR";
                    `FN_SLT:     mnemonic = "SLT";
                    `FN_SLTU:    mnemonic = "SLTU";
                    // Register traps
                    `FN_TGE:     mnemonic = "TGE";
                    `FN_TGEU:    mnemonic = "TGEU";
                    `FN_TLT:     mnemonic = "TLT";
                    `FN_TLTU:    mnemonic = "TLTU";
                    `FN_TEQ:     mnemonic = "TEQ";
                    `FN_TNE:     mnemonic = "TNE";
                    default:     mnemonic = "N-R";
                endcase
            end

            `OP_REGIMM: begin
                case (instr[20:16])
                    `RT_BLTZ:    mnemonic = "BLTZ";
                    `RT_BGEZ:    mnemonic = "BGEZ";
                    `RT_BLTZAL:  mnemonic = "BLTZAL";
                    `RT_BGEZAL:  mnemonic = "BGEZAL";
                    `RT_TGEI:    mnemonic = "TGEI";
                    `RT_TGEIU:   mnemonic = "TGEIU";
                    `RT_TLTI:    mnemonic = "TLTI";
                    `RT_TLTIU:   mnemonic = "TLTIU";
                    `RT_TEQI:    mnemonic = "TEQI";
                    `RT_TNEI:    mnemonic = "TNEI";
                    default:     mnemonic = "N-R";
                endcase
            end

            // Function field first, then the register moves by rs
            `OP_COP0: begin
                case (instr[5:0])
                    `FN_TLBR:    mnemonic = "TLBR";
                    `FN_TLBWI:   mnemonic = "TLBWI";
                    `FN_TLBP:    mnemonic = "TLBP";
                    `FN_ERET:    mnemonic = "ERET";
                    `FN_WAIT:    mnemonic = "WAIT";
                    default: begin
                        case (instr[25:21])
                            `RS_MFC0: mnemonic = "MFC0";
                            `RS_MTC0: mnemonic = "MTC0";
                            default:  mnemonic = "N-R";
                        endcase
                    end
                endcase
            end

            `OP_SPECIAL2: begin
                case (instr[5:0])
                    `FN_MADD:    mnemonic = "MADD";
                    `FN_MADDU:   mnemonic = "MADDU";
                    `FN_MUL:     mnemonic = "MUL";
                    `FN_MSUB:    mnemonic = "MSUB";
                    `FN_MSUBU:   mnemonic = "MSUBU";
                    `FN_CLZ:     mnemonic = "CLZ";
                    `FN_CLO:     mnemonic = "CLO";
                    default:     mnemonic = "N-R";
                endcase
            end

            // Jumps and branches
            `OP_J:       mnemonic = "J";
            `OP_JAL:     mnemonic = "JAL";
            `OP_BEQ:     mnemonic = "BEQ";
            `OP_BNE:     mnemonic = "BNE";
            `OP_BLEZ:    mnemonic = "BLEZ";
            `OP_BGTZ:    mnemonic = "BGTZ";
            // Immediate ALU
            `OP_ADDI:    mnemonic = "ADDI";
            `OP_ADDIU:   mnemonic = "ADDIU";
            `OP_SLTI:    mnemonic = "SLTI";
            `OP_SLTIU:   mnemonic = "SLTIU";
            `OP_ANDI:    mnemonic = "ANDI";
            `OP_ORI:     mnemonic = "ORI";
            `OP_XORI:    mnemonic = "XORI";
            `OP_LUI:     mnemonic = "LUI";
            // Loads and stores
            `OP_LB:      mnemonic = "LB";
            `OP_LH:      mnemonic = "LH";
            `OP_LWL:     mnemonic = "LWL";
            `OP_LW:      mnemonic = "LW";
            `OP_LBU:     mnemonic = "LBU";
            `OP_LHU:     mnemonic = "LHU";
            `OP_LWR:     mnemonic = "LWR";
            `OP_SB:      mnemonic = "SB";
            `OP_SH:      mnemonic = "SH";
            `OP_SWL:     mnemonic = "SWL";
            `OP_SW:      mnemonic = "SW";
            `OP_SWR:     mnemonic = "SWR";
            `OP_LL:      mnemonic = "LL";
            `OP_SC:      mnemonic = "SC";
            `OP_CACHE:   mnemonic = "CACHE";
            `OP_PREF:    mnemonic = "PREF";
            default:     mnemonic = "N-R";
        endcase

        // SLL $0,$0,0 is the canonical NOP
        if (instr == '0) begin
            mnemonic = "NOP";
        end
    end

endmodule

`default_nettype wire

/* src/itrace_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itrace_defines.svh"

module itrace_buffer (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               push,
    input  wire itrace_pkg::pc_t    push_pc,
    input  wire itrace_pkg::instr_t push_instr,
    input  wire logic               pop,
    output logic                    buf_empty,
    output itrace_pkg::pc_t         head_pc,
    output itrace_pkg::instr_t      head_instr,
    output logic                    credit_return
);

    localparam int PTR_W = $clog2(`ITRACE_BUF_DEPTH);

    itrace_pkg::pc_t     pc_mem    [`ITRACE_BUF_DEPTH];
    itrace_pkg::instr_t  instr_mem [`ITRACE_BUF_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    itrace_pkg::credit_t count;

    assign buf_empty  = (count == '0);
    assign head_pc    = pc_mem[rd_ptr];
    assign head_instr = instr_mem[rd_ptr];

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= push_pc;
            instr_mem[wr_ptr] <= push_instr;
        end
    end

    ////////////////////
    // Flow control checks

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> (count != itrace_pkg::credit_t'(`ITRACE_BUF_DEPTH)) || pop)
        else $error("push into a full buffer, credits out of step");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !buf_empty)
        else $error("pop from an empty buffer");

endmodule

`default_nettype wire

/* src/itrace_capture.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itrace_defines.svh"

module itrace_capture (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   retire_valid,
    input  wire itrace_pkg::pc_t        retire_pc,
    input  wire itrace_pkg::instr_t     retire_instr,
    input  wire logic                   credit_return,
    output logic                        push,
    output itrace_pkg::pc_t             push_pc,
    output itrace_pkg::instr_t          push_instr,
    output itrace_pkg::drop_count_t     drop_count
);

    itrace_pkg::credit_t credit_cnt;
    logic                take;

    // A credit coming back this cycle may be spent at once
    assign take = retire_valid && ((credit_cnt != '0) || credit_return);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= itrace_pkg::credit_t'(`ITRACE_BUF_DEPTH);
            push       <= 1'b0;
            drop_count <= '0;
        end else begin
            push <= take;
            case ({take, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            // No credit, the core cannot wait
            if (retire_valid && !take && (drop_count != '1)) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (take) begin
            push_pc    <= retire_pc;
            push_instr <= retire_instr;
        end
    end

    ////////////////////
    // Credit checks

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= itrace_pkg::credit_t'(`ITRACE_BUF_DEPTH))
        else $error("credit count above buffer depth");

    a_push_credit: assert property (@(posedge clk) disable iff (reset)
        push |-> ($past(credit_cnt) != '0) || $past(credit_return))
        else $error("push issued with no credit held");

endmodule

`default_nettype wire

/* src/itrace_emitter.sv */
`timescale 1ns/100ps
`default_nettype none

module itrace_emitter (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               buf_empty,
    input  wire itrace_pkg::pc_t    head_pc,
    input  wire itrace_pkg::instr_t head_instr,
    output logic                    pop,
    input  wire logic               out_ready,
    output logic                    out_valid,
    output itrace_pkg::pc_t         out_pc,
    output itrace_pkg::instr_t      out_instr,
    output itrace_pkg::mnemonic_t   out_mnemonic
);

    itrace_pkg::emit_state_t state;
    itrace_pkg::mnemonic_t   head_mnemonic;

    inst_ascii_decoder i_decoder (
        .instr    (head_instr),
        .mnemonic (head_mnemonic)
    );

    // Refill in the same cycle the held record is taken
    assign pop       = !buf_empty && ((state == itrace_pkg::EMIT_IDLE) || out_ready);
    assign out_valid = (state == itrace_pkg::EMIT_HOLD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= itrace_pkg::EMIT_IDLE;
        end else if (pop) begin
            state <= itrace_pkg::EMIT_HOLD;
        end else if (out_ready) begin
            state <= itrace_pkg::EMIT_IDLE;
        end
    end

    // Output record
    always_ff @(posedge clk) begin
        if (pop) begin
            out_pc       <= head_pc;
            out_instr    <= head_instr;
            out_mnemonic <= head_mnemonic;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pc)
            && $stable(out_instr) && $stable(out_mnemonic))
        else $error("output record changed while stalled");

endmodule

`default_nettype wire

/* src/itrace_pkg.sv */
`default_nettype none

`include "itrace_defines.svh"

package itrace_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;

    // ASCII text, last character in the low byte
    typedef logic [8*`ITRACE_MNEM_CHARS-1:0] mnemonic_t;

    // Holds 0 up to the full depth
    typedef logic [$clog2(`ITRACE_BUF_DEPTH+1)-1:0] credit_t;

    typedef logic [15:0] drop_count_t;

    typedef enum logic {
        EMIT_IDLE,
        EMIT_HOLD
    } emit_state_t;

endpackage

`default_nettype wire

/* src/itrace_top.sv */
`timescale 1ns/100ps
`default_nettype none

module itrace_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   retire_valid,
    input  wire itrace_pkg::pc_t        retire_pc,
    input  wire itrace_pkg::instr_t     retire_instr,
    input  wire logic                   out_ready,
    output logic                        out_valid,
    output itrace_pkg::pc_t             out_pc,
    output itrace_pkg::instr_t          out_instr,
    output itrace_pkg::mnemonic_t       out_mnemonic,
    output itrace_pkg::drop_count_t     drop_count
);

    ////////////////////
    // Capture to buffer, credit based
    logic               push;
    itrace_pkg::pc_t    push_pc;
    itrace_pkg::instr_t push_instr;
    logic               credit_return;

    // Buffer to emitter
    logic               buf_empty;
    itrace_pkg::pc_t    head_pc;
    itrace_pkg::instr_t head_instr;
    logic               pop;

    itrace_capture i_capture (
        .clk           (clk),
        .reset         (reset),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_instr  (retire_instr),
        .credit_return (credit_return),
        .push          (push),
        .push_pc       (push_pc),
        .push_instr    (push_instr),
        .drop_count    (drop_count)
    );

    itrace_buffer i_buffer (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_pc       (push_pc),
        .push_instr    (push_instr),
        .pop           (pop),
        .buf_empty     (buf_empty),
        .head_pc       (head_pc),
        .head_instr    (head_instr),
        .credit_return (credit_return)
    );

    itrace_emitter i_emitter (
        .clk          (clk),
        .reset        (reset),
        .buf_empty    (buf_empty),
        .head_pc      (head_pc),
        .head_instr   (head_instr),
        .pop          (pop),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_instr    (out_instr),
        .out_mnemonic (out_mnemonic)
    );

endmodule

`default_nettype wire
